// File: tb/uba_tests.txt
# name addr wdata respMask devData devIntr expData expAck expBusIntr[1:7] expDevReset
# Hex fields except expAck/expDevReset (decimal) and busIntr (binary, PI 1 leftmost)
# Device i answers with devData+i; devIntr nibble i holds device i levels 7..4
statWrIni   04907E640 00000006A 0 000000000 0000 000000000 1 0000000 1
statRdIni   10907E640 000000000 0 000000000 0000 00000006A 1 0000000 1
devRdDev2   10907E008 000000000 4 0ABCDEF00 0000 0ABCDEF02 1 0000000 1
devRdPrio   10907E008 000000000 A 123456780 0000 123456781 1 0000000 1
devWrNxd    04907E008 000000555 0 000000000 0000 000000000 0 0000000 1
statRdNxd   10907E640 000000000 0 000000000 0000 00000406A 1 0000000 1
statWrClr   04907E640 00000406A 0 000000000 0000 00000406A 1 0000000 1
statRdClr   10907E640 000000000 0 000000000 0000 00000006A 1 0000000 1
intrHigh    10907E640 000000000 0 000000000 0004 00000086A 1 0000100 1
intrLow     10907E640 000000000 0 000000000 0100 00000046A 1 0100000 1
wruHit      109940000 000000000 0 000000000 0000 000000002 1 0000000 1
wruMiss     1098C0000 000000000 0 000000000 0000 000000000 0 0000000 1
statWrIniOf 04907E640 00000002A 0 000000000 0000 00000006A 1 0000000 0

// File: flist.f
+incdir+design
design/uba_pkg.sv
design/ubaDecode.sv
design/ubaStatus.sv
design/ubaIntr.sv
design/ubaCtrl.sv
design/uba.sv
tb/uba_properties.sv
tb/uba_tb.sv

// File: Bender.yml
package:
  name: uba

export_include_dirs:
  - design

sources:
  - files:
      - design/uba_pkg.sv
      - design/ubaDecode.sv
      - design/ubaStatus.sv
      - design/ubaIntr.sv
      - design/ubaCtrl.sv
      - design/uba.sv
  - target: test
    files:
      - tb/uba_properties.sv
      - tb/uba_tb.sv

// File: tb/uba_tb.sv
/*
 * IO bridge testbench with clock, reset, CPU cycle driver, device model,
 * value checks and verdict
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module uba_tb;

   localparam int maxWait = 20;                  // CPU gives up after this

   logic                   clk;
   logic                   rst;
   logic                   busReqI;
   logic [`UBA_WORD_W-1:0] busAddrI;
   logic [`UBA_WORD_W-1:0] busDataI;
   logic                   busAckO;
   logic [`UBA_WORD_W-1:0] busDataO;
   logic [1:7]             busIntr;
   logic                   devReqO;
   logic [`UBA_WORD_W-1:0] devAddrO;
   logic [`UBA_WORD_W-1:0] devDataO;
   logic                   devAckI [`UBA_NUM_DEV];
   logic [`UBA_WORD_W-1:0] devDataI [`UBA_NUM_DEV];
   logic [7:4]             devIntr [`UBA_NUM_DEV];
   logic                   devReset;

   // One entry per line of the test file
   string                  tName [$];
   logic [`UBA_WORD_W-1:0] tAddr [$];
   logic [`UBA_WORD_W-1:0] tWdata [$];
   logic [3:0]             tMask [$];
   logic [`UBA_WORD_W-1:0] tDevData [$];
   logic [15:0]            tIntr [$];
   logic [`UBA_WORD_W-1:0] tExpData [$];
   bit                     tExpAck [$];
   logic [1:7]             tExpIntr [$];
   bit                     tExpReset [$];

   logic [3:0] respMask;                         // Devices that answer
   int         devWait;
   int         errors;
   int         checks;
   int         assertFails;
   int         cycleCnt;
   int         cycleLimit = 0;

   uba u_uba
   (
      .clk      (clk),
      .rst      (rst),
      .busReqI  (busReqI),
      .busAddrI (busAddrI),
      .busDataI (busDataI),
      .busAckO  (busAckO),
      .busDataO (busDataO),
      .busIntr  (busIntr),
      .devReqO  (devReqO),
      .devAddrO (devAddrO),
      .devDataO (devDataO),
      .devAckI  (devAckI),
      .devDataI (devDataI),
      .devIntr  (devIntr),
      .devReset (devReset)
   );

   bind ubaCtrl uba_properties u_props
   (
      .clk      (clk),
      .rst      (rst),
      .busReqI  (busReqI),
      .busAckO  (busAckO),
      .busDataO (busDataO),
      .devReqO  (devReqO),
      .devAddrO (devAddrO),
      .devDataO (devDataO),
      .setNxd   (setNxd)
   );

   initial
   begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Watchdog armed once the tests are loaded
   initial
   begin
      cycleCnt = 0;
      forever
      begin
         @(posedge clk);
         cycleCnt++;
         if (cycleLimit > 0 && cycleCnt > cycleLimit)
         begin
            $display("Run stopped after %0d cycles, the tests did not finish", cycleCnt);
            $display("TB FAILED");
            $finish;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Device model acks three cycles after devReqO rises
   //////////////////////////////////////////////////////////////////////

   initial
   begin
      for (int i = 0; i < `UBA_NUM_DEV; i++)
         devAckI[i] = 1'b0;
      devWait = 0;
      forever
      begin
         @(posedge clk);
         if (devReqO === 1'b1)
         begin
            if (devWait == 2)
            begin
               for (int i = 0; i < `UBA_NUM_DEV; i++)
                  devAckI[i] <= respMask[i];     // Held until devReqO drops
            end
            else
               devWait <= devWait + 1;
         end
         else
         begin
            for (int i = 0; i < `UBA_NUM_DEV; i++)
               devAckI[i] <= 1'b0;
            devWait <= 0;
         end
      end
   end

   task automatic checkValue(input string testName, input string what,
                             input logic [`UBA_WORD_W-1:0] expected,
                             input logic [`UBA_WORD_W-1:0] actual);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("ERROR %s %s: expected %h, actual %h", testName, what, expected, actual);
      end
   endtask

   task automatic loadTests();
      int                     fd;
      int                     n;
      int                     expAck;
      int                     expReset;
      string                  line;
      string                  name;
      logic [`UBA_WORD_W-1:0] addr;
      logic [`UBA_WORD_W-1:0] wdata;
      logic [`UBA_WORD_W-1:0] devData;
      logic [`UBA_WORD_W-1:0] expData;
      logic [3:0]             mask;
      logic [15:0]            intr;
      logic [1:7]             expIntr;
      fd = $fopen("tb/uba_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Cannot open the test file tb/uba_tests.txt");
         errors++;
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line.getc(0) != "#")
         begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %d %b %d", name, addr, wdata, mask,
                        devData, intr, expData, expAck, expIntr, expReset);
            if (n != 10)
            begin
               $display("Malformed line in the test file: %s", line);
               errors++;
            end
            else
            begin
               tName.push_back(name);
               tAddr.push_back(addr);
               tWdata.push_back(wdata);
               tMask.push_back(mask);
               tDevData.push_back(devData);
               tIntr.push_back(intr);
               tExpData.push_back(expData);
               tExpAck.push_back(expAck != 0);
               tExpIntr.push_back(expIntr);
               tExpReset.push_back(expReset != 0);
            end
         end
      end
      $fclose(fd);
   endtask

   //////////////////////////////////////////////////////////////////////
   // One CPU bus cycle with its device setup and checks
   //////////////////////////////////////////////////////////////////////

   task automatic runTest(input int t);
      int                     waited;
      bit                     gotAck;
      bit                     sawReq;
      logic [`UBA_WORD_W-1:0] data;
      logic [`UBA_WORD_W-1:0] reqAddr;
      logic [`UBA_WORD_W-1:0] reqData;
      @(posedge clk);
      respMask <= tMask[t];
      for (int i = 0; i < `UBA_NUM_DEV; i++)
      begin
         devIntr[i]  <= tIntr[t][4*i +: 4];
         devDataI[i] <= tDevData[t] + i;         // Device i answers data + i
      end
      repeat (3) @(posedge clk);                 // Let busIntr settle
      busReqI  <= 1'b1;
      busAddrI <= tAddr[t];
      busDataI <= tWdata[t];

      waited  = 0;
      gotAck  = 1'b0;
      sawReq  = 1'b0;
      data    = '0;
      reqAddr = '0;
      reqData = '0;
      while (!gotAck && waited < maxWait)
      begin
         @(negedge clk);
         if (devReqO === 1'b1)
         begin
            sawReq  = 1'b1;                      // Forwarded cycle seen
            reqAddr = devAddrO;
            reqData = devDataO;
         end
         if (busAckO === 1'b1)
         begin
            gotAck = 1'b1;
            data   = busDataO;
         end
         else
            waited++;
      end
      @(posedge clk);
      busReqI <= 1'b0;

      waited = 0;
      @(negedge clk);
      while (busAckO === 1'b1 && waited < 3)
      begin
         @(negedge clk);
         waited++;
      end
      if (busAckO !== 1'b0)
      begin
         $display("Test %s: busAckO stayed high after the request dropped", tName[t]);
         errors++;
      end
      if (devReqO !== 1'b0)
      begin
         $display("Test %s: devReqO stayed high after the cycle ended", tName[t]);
         errors++;
      end

      checkValue(tName[t], "ack", tExpAck[t], gotAck);
      if (tExpAck[t] && gotAck)
         checkValue(tName[t], "busDataO", tExpData[t], data);
      if (sawReq)
      begin
         checkValue(tName[t], "devAddrO", tAddr[t], reqAddr);
         checkValue(tName[t], "devDataO", tWdata[t], reqData);
      end
      checkValue(tName[t], "busIntr", tExpIntr[t], busIntr);
      checkValue(tName[t], "devReset", tExpReset[t], devReset);
   endtask

   initial
   begin
      rst      = 1'b1;
      busReqI  = 1'b0;
      busAddrI = '0;
      busDataI = '0;
      respMask = '0;
      for (int i = 0; i < `UBA_NUM_DEV; i++)
      begin
         devDataI[i] = '0;
         devIntr[i]  = '0;
      end
      errors = 0;
      checks = 0;
      loadTests();
      if (tName.size() == 0 && errors == 0)
      begin
         $display("The test file holds no tests");
         errors++;
      end
      if (errors == 0)
      begin
         cycleLimit = 40 * tName.size();
         repeat (16) @(posedge clk);
         rst <= 1'b0;
         for (int t = 0; t < tName.size(); t++)
            runTest(t);
         repeat (2) @(posedge clk);
      end
      assertFails = u_uba.u_ctrl.u_props.failCount;
      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checks, errors, assertFails);
      if (errors == 0 && assertFails == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// File: tb/uba_properties.sv
/*
 * Concurrent assertions on the transfer FSM handshake and reset values
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module uba_properties
(
   input logic                   clk,
   input logic                   rst,
   input logic                   busReqI,
   input logic                   busAckO,
   input logic [`UBA_WORD_W-1:0] busDataO,
   input logic                   devReqO,
   input logic [`UBA_WORD_W-1:0] devAddrO,
   input logic [`UBA_WORD_W-1:0] devDataO,
   input logic                   setNxd
);

   int failCount = 0;

   resetOutputs: assert property (@(posedge clk)
      rst |=> !busAckO && !devReqO && !setNxd &&
              busDataO == '0 && devAddrO == '0 && devDataO == '0)
   else
   begin
      $error("Controller outputs not cleared by reset");
      failCount++;
   end

   // Never answer the CPU while a device cycle is open
   ackReqExclusive: assert property (@(posedge clk) disable iff (rst)
      !(busAckO && devReqO))
   else
   begin
      $error("busAckO and devReqO high together");
      failCount++;
   end

   ackFollowsReq: assert property (@(posedge clk) disable iff (rst)
      $fell(busReqI) |-> ##[0:2] !busAckO)
   else
   begin
      $error("busAckO still high two cycles after busReqI fell");
      failCount++;
   end

   nxdPulse: assert property (@(posedge clk) disable iff (rst)
      setNxd |=> !setNxd)
   else
   begin
      $error("setNxd high for more than one cycle");
      failCount++;
   end

endmodule

// File: design/uba.sv
/*
 * IO bridge top level: decode, status, interrupts and transfer control
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module uba import uba_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   // Backplane side
   input  logic       busReqI,
   input  word_t      busAddrI,
   input  word_t      busDataI,
   output logic       busAckO,
   output word_t      busDataO,
   output logic [1:7] busIntr,
   // Device side, outputs broadcast
   output logic       devReqO,
   output word_t      devAddrO,
   output word_t      devDataO,
   input  logic       devAckI [`UBA_NUM_DEV],
   input  word_t      devDataI [`UBA_NUM_DEV],
   input  logic [7:4] devIntr [`UBA_NUM_DEV],
   output logic       devReset
);

   cycleKind_e cycleKind;
   word_t      statWord;
   logic [2:0] pih;
   logic [2:0] pil;
   logic       intHi;
   logic       intLo;
   logic       wruHit;
   logic       statWrite;
   logic       setNxd;

   ubaDecode u_decode
   (
      .busAddrI  (busAddrI),
      .cycleKind (cycleKind)
   );

   ubaStatus u_status
   (
      .clk       (clk),
      .rst       (rst),
      .busDataI  (busDataI),
      .statWrite (statWrite),
      .setNxd    (setNxd),
      .intHi     (intHi),
      .intLo     (intLo),
      .statWord  (statWord),
      .pih       (pih),
      .pil       (pil),
      .devReset  (devReset)
   );

   ubaIntr u_intr
   (
      .clk       (clk),
      .rst       (rst),
      .devIntr   (devIntr),
      .pih       (pih),
      .pil       (pil),
      .busAddrI  (busAddrI),
      .intHi     (intHi),
      .intLo     (intLo),
      .busIntr   (busIntr),
      .wruHit    (wruHit)
   );

   ubaCtrl u_ctrl
   (
      .clk       (clk),
      .rst       (rst),
      .busReqI   (busReqI),
      .busAddrI  (busAddrI),
      .busDataI  (busDataI),
      .cycleKind (cycleKind),
      .wruHit    (wruHit),
      .statWord  (statWord),
      .devAckI   (devAckI),
      .devDataI  (devDataI),
      .busAckO   (busAckO),
      .busDataO  (busDataO),
      .devReqO   (devReqO),
      .devAddrO  (devAddrO),
      .devDataO  (devDataO),
      .statWrite (statWrite),
      .setNxd    (setNxd)
   );

endmodule

// File: design/ubaCtrl.sv
/*
 * Transfer FSM for status, WRU and forwarded device cycles with NXD timer
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module ubaCtrl import uba_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       busReqI,
   input  word_t      busAddrI,
   input  word_t      busDataI,
   input  cycleKind_e cycleKind,
   input  logic       wruHit,
   input  word_t      statWord,
   input  logic       devAckI [`UBA_NUM_DEV],
   input  word_t      devDataI [`UBA_NUM_DEV],
   output logic       busAckO,
   output word_t      busDataO,
   output logic       devReqO,
   output word_t      devAddrO,
   output word_t      devDataO,
   output logic       statWrite,
   output logic       setNxd
);

   ctrlState_e state;
   logic [3:0] nxdCnt;
   logic       ackHit;
   word_t      ackData;

   //////////////////////////////////////////////////////////////////////
   // Device acknowledge priority, lowest index wins
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      ackHit  = 1'b0;
      ackData = '0;
      for (int i = `UBA_NUM_DEV - 1; i >= 0; i--)
      begin
         if (devAckI[i])
         begin
            ackHit  = 1'b1;
            ackData = devDataI[i];
         end
      end
   end

   // Status register loads on the edge that takes the cycle
   assign statWrite = (state == stIdle) && busReqI && (cycleKind == cycStatWr);

   //////////////////////////////////////////////////////////////////////
   // Transfer state machine
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state    <= stIdle;
         busAckO  <= 1'b0;
         busDataO <= '0;
         devReqO  <= 1'b0;
         devAddrO <= '0;
         devDataO <= '0;
         nxdCnt   <= 4'd0;
         setNxd   <= 1'b0;
      end
      else
      begin
         setNxd <= 1'b0;
         case (state)
            stIdle:
            begin
               if (busReqI)
               begin
                  case (cycleKind)
                     cycStatRd, cycStatWr:
                     begin
                        busAckO  <= 1'b1;
                        busDataO <= statWord;
                        state    <= stWaitBusReq;
                     end
                     cycWru:
                     begin
                        if (wruHit)                // Otherwise another bridge owns it
                        begin
                           busAckO  <= 1'b1;
                           busDataO <= `UBA_WRU_RESP;
                           state    <= stWaitBusReq;
                        end
                     end
                     cycDevRd, cycDevWr:
                     begin
                        devReqO  <= 1'b1;
                        devAddrO <= busAddrI;
                        devDataO <= busDataI;
                        nxdCnt   <= 4'(`UBA_NXD_TIMEOUT - 1);
                        state    <= stCpuToDev;
                     end
                     default:
                     begin
                        state <= stIdle;
                     end
                  endcase
               end
            end

            stCpuToDev:
            begin
               if (ackHit)
               begin
                  busAckO  <= 1'b1;
                  busDataO <= ackData;
                  devReqO  <= 1'b0;
                  state    <= stWaitBusReq;
               end
               else if (!busReqI)
                  state <= stDone;                 // CPU gave up
               else if (nxdCnt != 4'd0)
                  nxdCnt <= nxdCnt - 4'd1;
               else
               begin
                  setNxd  <= 1'b1;                 // Nobody home
                  devReqO <= 1'b0;
                  state   <= stWaitBusReq;
               end
            end

            stWaitBusReq:
            begin
               if (!busReqI)
               begin
                  busAckO <= 1'b0;
                  state   <= stIdle;
               end
            end

            stDone:
            begin
               busAckO <= 1'b0;
               devReqO <= 1'b0;
               state   <= stIdle;
            end

            default:
            begin
               state <= stIdle;
            end
         endcase
      end
   end

endmodule

// File: design/ubaIntr.sv
/*
 * Device interrupt levels onto backplane PI lines, WRU match
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module ubaIntr import uba_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic [7:4] devIntr [`UBA_NUM_DEV],
   input  logic [2:0] pih,
   input  logic [2:0] pil,
   input  word_t      busAddrI,
   output logic       intHi,
   output logic       intLo,
   output logic [1:7] busIntr,
   output logic       wruHit
);

   logic [2:0] busPi;
   logic [1:7] intrNext;

   // Levels 7/6 share the high PI, 5/4 the low one
   always_comb
   begin
      intHi = 1'b0;
      intLo = 1'b0;
      for (int i = 0; i < `UBA_NUM_DEV; i++)
      begin
         intHi = intHi | devIntr[i][7] | devIntr[i][6];
         intLo = intLo | devIntr[i][5] | devIntr[i][4];
      end
   end

   always_comb
   begin
      intrNext = '0;
      if (intHi && pih != 3'd0)
         intrNext[pih] = 1'b1;
      if (intLo && pil != 3'd0)
         intrNext[pil] = 1'b1;                   // PI 0 means disabled
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         busIntr <= '0;
      else
         busIntr <= intrNext;
   end

   assign busPi  = busAddrI[`UBA_PI_LSB +: 3];
   assign wruHit = (pih != 3'd0 && busPi == pih) || (pil != 3'd0 && busPi == pil);

endmodule

// File: design/ubaStatus.sv
/*
 * Status register: sticky NXD/TMO, PI levels, INI and live interrupt bits
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module ubaStatus import uba_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  word_t      busDataI,
   input  logic       statWrite,
   input  logic       setNxd,
   input  logic       intHi,
   input  logic       intLo,
   output word_t      statWord,
   output logic [2:0] pih,
   output logic [2:0] pil,
   output logic       devReset
);

   logic tmo;
   logic nxd;
   logic ini;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         tmo <= 1'b0;
         nxd <= 1'b0;
         ini <= 1'b0;
         pih <= 3'd0;
         pil <= 3'd0;
      end
      else
      begin
         if (statWrite)
         begin
            if (busDataI[`ST_TMO])
               tmo <= 1'b0;                      // Write one to clear
            if (busDataI[`ST_NXD])
               nxd <= 1'b0;
            ini <= busDataI[`ST_INI];
            pih <= busDataI[`ST_PIH_LSB +: 3];
            pil <= busDataI[`ST_PIL_LSB +: 3];
         end
         if (setNxd)
            nxd <= 1'b1;                         // A new error beats the clear
      end
   end

   always_comb
   begin
      statWord                  = '0;
      statWord[`ST_TMO]         = tmo;
      statWord[`ST_NXD]         = nxd;
      statWord[`ST_INTHI]       = intHi;
      statWord[`ST_INTLO]       = intLo;
      statWord[`ST_INI]         = ini;
      statWord[`ST_PIH_LSB +: 3] = pih;
      statWord[`ST_PIL_LSB +: 3] = pil;
   end

   assign devReset = ini;

endmodule

// File: design/ubaDecode.sv
/*
 * Backplane address word decode into a cycle kind
 */
`timescale 1ns/1ps
`include "uba_params.svh"

module ubaDecode import uba_pkg::*;
(
   input  word_t      busAddrI,
   output cycleKind_e cycleKind
);

   localparam logic [`UBA_ADDR_W-1:0] baseAddr = `UBA_BASE;
   localparam logic [`UBA_ADDR_W-1:0] statAddr = `UBA_BASE + `UBA_STAT_OFS;

   logic                   isRead;
   logic                   isWrite;
   logic                   isPhysIo;
   logic                   isWru;
   logic                   ourBridge;
   logic [`UBA_ADDR_W-1:0] ioAddr;

   assign isRead    = busAddrI[`UBA_READ_BIT];
   assign isWrite   = busAddrI[`UBA_WRITE_BIT];
   assign isPhysIo  = busAddrI[`UBA_PHYS_BIT] & busAddrI[`UBA_IO_BIT];
   assign isWru     = busAddrI[`UBA_WRU_BIT];
   assign ourBridge = (busAddrI[`UBA_DEV_LSB +: 4] == `UBA_NUM);
   assign ioAddr    = busAddrI[`UBA_ADDR_W-1:0];

   always_comb
   begin
      cycleKind = cycNone;
      if (isPhysIo)
      begin
         if (isWru)
         begin
            if (isRead)
               cycleKind = cycWru;               // Any bridge may answer
         end
         else if (ourBridge && ioAddr == statAddr)
            cycleKind = isRead ? cycStatRd : (isWrite ? cycStatWr : cycNone);
         else if (ourBridge &&
                  ioAddr[`UBA_ADDR_W-1:`UBA_BLK_LSB] != baseAddr[`UBA_ADDR_W-1:`UBA_BLK_LSB])
            cycleKind = isRead ? cycDevRd : (isWrite ? cycDevWr : cycNone);
      end
   end

endmodule

// File: design/uba_pkg.sv
/*
 * Bus word type, cycle kinds and controller states
 */
`include "uba_params.svh"

package uba_pkg;

   typedef logic [`UBA_WORD_W-1:0] word_t;

   // What the decoder made of the address word
   typedef enum logic [2:0]
   {
      cycNone,
      cycStatRd,
      cycStatWr,
      cycWru,
      cycDevRd,
      cycDevWr
   } cycleKind_e;

   typedef enum logic [1:0]
   {
      stIdle,
      stCpuToDev,      // Forwarded cycle in flight
      stWaitBusReq,    // Hold until the CPU drops its request
      stDone
   } ctrlState_e;

endpackage

// File: design/uba_params.svh
/*
 * Bridge widths, address-word bit positions, register offsets,
 * NXD timeout, bridge number and status register bit positions
 */
`ifndef UBA_PARAMS_SVH
`define UBA_PARAMS_SVH

`define UBA_WORD_W      36
`define UBA_NUM_DEV     4
`define UBA_ADDR_W      18

// Address word flags (KS10 bit n sits at index 35-n)
`define UBA_READ_BIT    32
`define UBA_WRITE_BIT   30
`define UBA_PHYS_BIT    27
`define UBA_IO_BIT      24
`define UBA_WRU_BIT     23
`define UBA_PI_LSB      18        // 3-bit PI field, WRU cycles only
`define UBA_DEV_LSB     18        // 4-bit bridge number
`define UBA_BLK_LSB     7         // Bridge register block is 128 words

`define UBA_NUM         4'd1
`define UBA_BASE        18'o763000
`define UBA_STAT_OFS    18'o000100
`define UBA_WRU_RESP    (36'd1 << `UBA_NUM)
`define UBA_NXD_TIMEOUT 8

// Status register bits
`define ST_TMO          17
`define ST_NXD          14
`define ST_INTHI        11
`define ST_INTLO        10
`define ST_INI          6
`define ST_PIH_LSB      3
`define ST_PIL_LSB      0

`endif
